// File: bench/rob_tb.sv
`timescale 1ns/1ps

module rob_tb;

    import rob_pkg::*;

    localparam int CYCLES_PER_RECORD = 40;

    typedef struct packed {
        robn_t           robn;                  // expected slot of way 0
        dispatch_group_t grp;
    } disp_req_t;

    logic                        clock;
    logic                        reset;
    logic                        disp_valid;
    dispatch_group_t             disp_group;
    fu_rob_packet_t [CDB_SZ-1:0] cdb;
    logic                        stall;
    robn_t [WAYS-1:0]            disp_robn;
    retire_rec_t                 retire;
    redirect_t                   redirect;

    disp_req_t      disp_q[$];                  // groups waiting for dispatch
    fu_rob_packet_t pending[$];                 // completions not yet sent
    retire_way_t    exp_retire_q[$];            // program order
    redirect_t      exp_redirect_q[$];

    logic             presenting;
    logic             stall_s;
    robn_t [WAYS-1:0] robn_s;
    bit               dual_seen = 1'b0;         // both ways retired in one cycle
    integer           seed = 32'hdf2;
    int               errors = 0;
    int               tests = 0;
    int               failed_tests = 0;
    int               cycles = 0;
    int               limit = 0;

    rob_core_top uut (
        .clock      (clock),
        .reset      (reset),
        .disp_valid (disp_valid),
        .disp_group (disp_group),
        .cdb        (cdb),
        .stall      (stall),
        .disp_robn  (disp_robn),
        .retire     (retire),
        .redirect   (redirect)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial begin
        forever begin
            @(posedge clock);
            cycles = cycles + 1;
            if (limit > 0 && cycles > limit) begin
                $display("timeout: the run did not finish within %0d cycles", limit);
                $display("Simulation failed");
                $finish;
            end
        end
    end

    task automatic check_retire(input retire_rec_t got, input retire_rec_t exp);
        for (int i = 0; i < WAYS; i++) begin
            if (got.ways[i].valid !== exp.ways[i].valid ||
                (exp.ways[i].valid && (got.ways[i].dest !== exp.ways[i].dest ||
                 got.ways[i].wr !== exp.ways[i].wr ||
                 got.ways[i].value !== exp.ways[i].value))) begin
                $display({"error %0t: retire way %0d got v%0b r%0d w%0b %h, ",
                          "expected v%0b r%0d w%0b %h"},
                         $time, i, got.ways[i].valid, got.ways[i].dest, got.ways[i].wr,
                         got.ways[i].value, exp.ways[i].valid, exp.ways[i].dest,
                         exp.ways[i].wr, exp.ways[i].value);
                errors++;
            end
        end
    endtask

    task automatic check_redirect(input redirect_t got, input redirect_t exp);
        if (got.valid !== exp.valid || (exp.valid && got.pc !== exp.pc)) begin
            $display("error %0t: redirect got v%0b pc %h, expected v%0b pc %h",
                     $time, got.valid, got.pc, exp.valid, exp.pc);
            errors++;
        end
    endtask

    task automatic check_robn(input robn_t got, input robn_t exp, input int way);
        if (got !== exp) begin
            $display("error %0t: dispatch way %0d got rob number %0d, expected %0d",
                     $time, way, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error %0t: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic bit is_record(input string line);
        if (line.len() == 0) begin
            return 1'b0;
        end
        return line.substr(0, 0) != "#" && line.substr(0, 0) != "\n";
    endfunction

    // dispatch driver presents the next group on the edge that took the last one
    initial begin
        disp_valid = 1'b0;
        disp_group = '0;
        presenting = 1'b0;
        stall_s    = 1'b0;
        robn_s     = '0;
        forever begin
            @(negedge clock);
            stall_s = stall;
            robn_s  = disp_robn;
            @(posedge clock);
            if (presenting && !stall_s) begin
                check_robn(robn_s[0], disp_q[0].robn, 0);
                check_robn(robn_s[1], robn_t'(disp_q[0].robn + 1), 1);
                void'(disp_q.pop_front());
                presenting = 1'b0;
            end
            if (!presenting && !reset && disp_q.size() > 0) begin
                disp_valid <= 1'b1;
                disp_group <= disp_q[0].grp;
                presenting = 1'b1;
            end else if (!presenting) begin
                disp_valid <= 1'b0;
            end
        end
    end

    // output monitor comparing in arrival order
    initial begin
        retire_rec_t exp;
        redirect_t   exp_rd;
        forever begin
            @(negedge clock);
            exp = '0;
            for (int i = 0; i < WAYS; i++) begin
                if (retire.ways[i].valid && exp_retire_q.size() > 0) begin
                    exp.ways[i] = exp_retire_q.pop_front();
                end
            end
            exp_rd = '0;
            if (redirect.valid && exp_redirect_q.size() > 0) begin
                exp_rd = exp_redirect_q.pop_front();
            end
            if (!reset) begin
                if (retire.ways[WAYS-1].valid) begin
                    dual_seen = 1'b1;
                end
                check_retire(retire, exp);
                check_redirect(redirect, exp_rd);
            end
        end
    end

    task automatic settle();
        @(negedge clock);
        #1;
    endtask

    task automatic wait_drained();
        while (disp_q.size() > 0 || presenting) begin
            settle();
        end
        repeat (2) @(posedge clock);            // accepted group reaches the ROB
    endtask

    task automatic wait_stalled();
        while (!(presenting && stall)) begin
            settle();
        end
    endtask

    task automatic send_pending();
        fu_rob_packet_t tmp;
        int             j;
        for (int i = pending.size() - 1; i > 0; i--) begin
            j = $unsigned($random(seed)) % (i + 1);
            tmp        = pending[i];
            pending[i] = pending[j];
            pending[j] = tmp;
        end
        while (pending.size() > 0) begin
            @(posedge clock);
            for (int l = 0; l < CDB_SZ; l++) begin
                if (pending.size() > 0) begin
                    cdb[l] <= pending.pop_front();
                end else begin
                    cdb[l] <= '0;
                end
            end
        end
        @(posedge clock);
        cdb <= '0;
    endtask

    task automatic report_test(input string name, input int err0);
        tests++;
        if (errors == err0) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, errors - err0);
        end
    endtask

    initial begin
        int              fd;
        int              n;
        int              nrec;
        int              test_err0;
        int              base;
        string           line;
        string           kind;
        string           name;
        logic [31:0]     f[16];
        disp_req_t       req;
        fu_rob_packet_t  pkt;
        retire_way_t     rw;
        redirect_t       rd;

        reset = 1'b1;
        cdb   = '0;
        nrec  = 0;
        name  = "none";
        fd = $fopen("bench/rob_tb_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file bench/rob_tb_input.txt");
            $display("Simulation failed");
            $finish;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && is_record(line)) begin
                nrec++;
            end
        end
        $fclose(fd);
        limit = nrec * CYCLES_PER_RECORD;
        fd = $fopen("bench/rob_tb_input.txt", "r");

        repeat (3) @(posedge clock);
        reset <= 1'b0;
        settle();
        test_err0 = errors;
        check_flag(stall, 1'b0, "stall after reset");
        check_retire(retire, '0);
        check_redirect(redirect, '0);
        report_test("reset", test_err0);

        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 0 && is_record(line)) begin
                n = $sscanf(line, "%s", kind);
                if (kind == "T") begin
                    n = $sscanf(line, "%s %s", kind, name);
                    test_err0 = errors;
                end else if (kind == "D") begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                kind, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                                f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
                    req           = '0;
                    req.robn      = f[0][ROB_PTR_W-1:0];
                    req.grp.valid = f[1][WAYS-1:0];
                    for (int w = 0; w < WAYS; w++) begin
                        base = 2 + 7 * w;
                        req.grp.insts[w].pc             = f[base];
                        req.grp.insts[w].dest_arn       = f[base + 1][ARN_W-1:0];
                        req.grp.insts[w].wr_dest        = f[base + 2][0];
                        req.grp.insts[w].cond_branch    = f[base + 3][0];
                        req.grp.insts[w].uncond_branch  = f[base + 4][0];
                        req.grp.insts[w].predict_taken  = f[base + 5][0];
                        req.grp.insts[w].predict_target = f[base + 6];
                    end
                    disp_q.push_back(req);
                end else if (kind == "C") begin
                    n = $sscanf(line, "%s %h %h %h %h", kind, f[0], f[1], f[2], f[3]);
                    pkt          = '0;
                    pkt.executed = 1'b1;
                    pkt.robn     = f[0][ROB_PTR_W-1:0];
                    if (f[1][0]) begin
                        pkt.payload.br.taken  = f[2][0];
                        pkt.payload.br.target = f[3];
                    end else begin
                        pkt.payload.data.pad    = 1'b0;
                        pkt.payload.data.result = f[3];
                    end
                    pending.push_back(pkt);
                end else if (kind == "S") begin
                    n = $sscanf(line, "%s %h", kind, f[0]);
                    if (f[0][0]) begin
                        wait_drained();
                    end else begin
                        wait_stalled();         // older groups already in the ROB
                    end
                    send_pending();
                end else if (kind == "R") begin
                    n = $sscanf(line, "%s %h %h %h", kind, f[0], f[1], f[2]);
                    rw       = '0;
                    rw.valid = 1'b1;
                    rw.dest  = f[0][ARN_W-1:0];
                    rw.wr    = f[1][0];
                    rw.value = f[2];
                    exp_retire_q.push_back(rw);
                end else if (kind == "X") begin
                    n = $sscanf(line, "%s %h", kind, f[0]);
                    rd.valid = 1'b1;
                    rd.pc    = f[0];
                    exp_redirect_q.push_back(rd);
                end else if (kind == "E") begin
                    while (exp_retire_q.size() > 0 || exp_redirect_q.size() > 0 ||
                           disp_q.size() > 0 || presenting) begin
                        settle();
                    end
                    repeat (2) settle();        // catch stray retires
                    report_test(name, test_err0);
                end else begin
                    $display("unknown record kind %s in the stimulus file", kind);
                    errors++;
                end
            end
        end
        $fclose(fd);

        if (!dual_seen) begin
            $display("no cycle retired two instructions at once");
            errors++;
        end

        $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: bench/rob_tb_input.txt
# D robn mask, then per way: pc dest wr cond uncond pred_taken pred_target
# C robn is_branch taken value | S wait_drained | R dest wr value | X pc | T name | E
T in_order
R 1 1 11111111
R 2 1 22222222
R 3 1 33333333
R 4 1 44444444
D 0 3 00000100 1 1 0 0 0 00000000 00000104 2 1 0 0 0 00000000
D 2 3 00000108 3 1 0 0 0 00000000 0000010c 4 1 0 0 0 00000000
C 0 0 0 11111111
C 1 0 0 22222222
C 2 0 0 33333333
C 3 0 0 44444444
S 1
E
T back_pressure
R 5 1 a0000001
R 6 1 a0000002
R 7 1 a0000003
R 1 1 a0000004
R 2 1 a0000005
R 3 1 a0000006
R 4 1 a0000007
R 5 1 a0000008
R 6 1 a0000009
R 7 1 a000000a
D 4 3 00000200 5 1 0 0 0 00000000 00000204 6 1 0 0 0 00000000
D 6 3 00000208 7 1 0 0 0 00000000 0000020c 1 1 0 0 0 00000000
D 0 3 00000210 2 1 0 0 0 00000000 00000214 3 1 0 0 0 00000000
D 2 3 00000218 4 1 0 0 0 00000000 0000021c 5 1 0 0 0 00000000
D 4 3 00000220 6 1 0 0 0 00000000 00000224 7 1 0 0 0 00000000
C 4 0 0 a0000001
C 5 0 0 a0000002
C 6 0 0 a0000003
C 7 0 0 a0000004
S 0
C 0 0 0 a0000005
C 1 0 0 a0000006
C 2 0 0 a0000007
C 3 0 0 a0000008
S 1
C 4 0 0 a0000009
C 5 0 0 a000000a
S 1
E
T branch_ok
R 0 0 00000000
R 6 1 66666666
D 6 3 00000300 0 0 1 0 1 00000400 00000304 6 1 0 0 0 00000000
C 6 1 1 00000400
C 7 0 0 66666666
S 1
E
T mispredict_target
X 00000700
D 0 3 00000500 0 0 1 0 1 00000600 00000504 7 1 0 0 0 00000000
C 0 1 1 00000700
C 1 0 0 77777777
S 1
E
T after_flush
R 7 1 aaaaaaaa
R 1 1 bbbbbbbb
D 0 3 00000700 7 1 0 0 0 00000000 00000704 1 1 0 0 0 00000000
C 0 0 0 aaaaaaaa
C 1 0 0 bbbbbbbb
S 1
E
T mispredict_not_taken
X 00000804
D 2 3 00000800 0 0 1 0 1 00000900 00000804 3 1 0 0 0 00000000
C 2 1 0 00000900
C 3 0 0 cccccccc
S 1
E
T single_way
R 2 1 dddddddd
D 0 1 00000808 2 1 0 0 0 00000000 00000000 0 0 0 0 0 00000000
C 0 0 0 dddddddd
S 1
E

// File: hdl/commit_unit.sv
`timescale 1ns/1ps

module commit_unit (
    input  logic                    clock,
    input  logic                    reset,
    input  rob_pkg::rob_ct_packet_t ct,
    input  logic                    squash,
    output rob_pkg::retire_rec_t    retire,
    output rob_pkg::redirect_t      redirect
);

    import rob_pkg::*;

    logic [XLEN-1:0] arch_regs [ARCH_REGS];
    rob_entry_t      br;                        // entry that raised the squash
    retire_rec_t     next_retire;

    // first non-retiring slot holds the mispredicted branch
    always_comb begin
        br = ct.entries[0];
        for (int i = WAYS - 1; i >= 0; i--) begin
            if (!ct.valid[i]) begin
                br = ct.entries[i];
            end
        end
    end

    // value is what dest holds once this instruction has retired
    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            next_retire.ways[i].valid = ct.valid[i];
            next_retire.ways[i].dest  = ct.entries[i].dest_arn;
            next_retire.ways[i].wr    = ct.entries[i].wr_dest;
            if (ct.entries[i].wr_dest) begin
                next_retire.ways[i].value = ct.entries[i].result;
            end else begin
                next_retire.ways[i].value = arch_regs[ct.entries[i].dest_arn];
                for (int j = 0; j < i; j++) begin
                    if (ct.valid[j] && ct.entries[j].wr_dest &&
                        ct.entries[j].dest_arn == ct.entries[i].dest_arn) begin
                        next_retire.ways[i].value = ct.entries[j].result;  // same group
                    end
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < ARCH_REGS; r++) begin
                arch_regs[r] <= '0;
            end
        end else begin
            for (int i = 0; i < WAYS; i++) begin
                if (ct.valid[i] && ct.entries[i].wr_dest) begin
                    arch_regs[ct.entries[i].dest_arn] <= ct.entries[i].result;  // younger wins
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            retire   <= '0;
            redirect <= '0;
        end else begin
            retire         <= next_retire;
            redirect.valid <= squash;
            redirect.pc    <= br.resolve_taken ? br.resolve_target : br.pc + XLEN'(4);
        end
    end

endmodule

// File: hdl/dispatch_stage.sv
`timescale 1ns/1ps

module dispatch_stage (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               disp_valid,
    input  rob_pkg::dispatch_group_t           disp_group,
    input  logic                               almost_full,
    input  logic                               squash,
    input  rob_pkg::robn_t [rob_pkg::WAYS-1:0] tail_entries,
    output logic                               stall,
    output rob_pkg::robn_t [rob_pkg::WAYS-1:0] disp_robn,
    output rob_pkg::rob_is_packet_t            is_packet
);

    import rob_pkg::*;

    rob_entry_t [WAYS-1:0] new_entries;
    rob_entry_t [WAYS-1:0] entries_q;
    logic       [WAYS-1:0] valid_q;
    logic                  accept;

    assign stall  = almost_full;
    assign accept = disp_valid && !stall && !squash;

    // slots the group will occupy, after the one still held here
    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            disp_robn[i] = robn_t'(tail_entries[i] + $countones(valid_q));
        end
    end

    // fresh entry per way with executed clear and success set
    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            new_entries[i]                = '0;
            new_entries[i].success        = 1'b1;
            new_entries[i].pc             = disp_group.insts[i].pc;
            new_entries[i].dest_arn       = disp_group.insts[i].dest_arn;
            new_entries[i].wr_dest        = disp_group.insts[i].wr_dest;
            new_entries[i].cond_branch    = disp_group.insts[i].cond_branch;
            new_entries[i].uncond_branch  = disp_group.insts[i].uncond_branch;
            new_entries[i].predict_taken  = disp_group.insts[i].predict_taken;
            new_entries[i].predict_target = disp_group.insts[i].predict_target;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_q <= '0;
        end else if (accept) begin
            valid_q <= disp_group.valid;
        end else begin
            valid_q <= '0;                      // one cycle per group
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            entries_q <= new_entries;
        end
    end

    assign is_packet = '{valid: valid_q, entries: entries_q};

endmodule

// File: hdl/rob.sv
`timescale 1ns/1ps

module rob (
    input  logic                                        clock,
    input  logic                                        reset,
    input  rob_pkg::rob_is_packet_t                     is_packet,
    input  rob_pkg::fu_rob_packet_t [rob_pkg::CDB_SZ-1:0] cdb,
    output logic                                        almost_full,
    output rob_pkg::robn_t [rob_pkg::WAYS-1:0]          tail_entries,
    output rob_pkg::rob_ct_packet_t                     ct,
    output logic                                        squash
);

    import rob_pkg::*;

    logic [ROB_CNT_W-1:0] count, next_count;
    robn_t                head, next_head;
    robn_t                tail, next_tail;

    rob_entry_t [ROB_SZ-1:0] rob_entries, next_entries;

    rob_entry_t upd;                            // entry under completion
    logic       blocked;                        // retire stopped this cycle

    // leaves room for one group in dispatch and one being written
    assign almost_full = (count > ROB_CNT_W'(ROB_SZ - 2 * WAYS));

    always_comb begin
        for (int i = 0; i < WAYS; i++) begin
            tail_entries[i] = robn_t'(tail + i);
        end
    end

    always_comb begin
        next_head    = head;
        next_tail    = tail;
        next_count   = count;
        next_entries = rob_entries;
        ct           = '0;
        squash       = 1'b0;
        blocked      = 1'b0;
        upd          = '0;

        // in-order retire from the head
        for (int i = 0; i < WAYS; i++) begin
            if (!blocked && next_count != 0 && rob_entries[next_head].executed) begin
                if (rob_entries[next_head].success) begin
                    ct.valid[i]   = 1'b1;
                    ct.entries[i] = rob_entries[next_head];
                    next_head     = next_head + 1'b1;
                    next_count    = next_count - 1'b1;
                end else begin
                    // mispredicted branch rides in the slot but does not retire
                    ct.entries[i] = rob_entries[next_head];
                    squash        = 1'b1;
                    blocked       = 1'b1;
                    next_head     = '0;
                    next_tail     = '0;
                    next_count    = '0;
                end
            end else begin
                blocked = 1'b1;
            end
        end

        // allocate the registered dispatch group
        if (!squash) begin
            for (int i = 0; i < WAYS; i++) begin
                if (is_packet.valid[i]) begin
                    next_entries[next_tail] = is_packet.entries[i];
                    next_tail               = next_tail + 1'b1;
                    next_count              = next_count + 1'b1;
                end
            end
        end

        // completion bus update with the payload view picked by entry kind
        if (!squash) begin
            for (int i = 0; i < CDB_SZ; i++) begin
                if (cdb[i].executed) begin
                    upd          = next_entries[cdb[i].robn];
                    upd.executed = 1'b1;
                    if (upd.cond_branch || upd.uncond_branch) begin
                        upd.resolve_taken  = cdb[i].payload.br.taken;
                        upd.resolve_target = cdb[i].payload.br.target;
                        upd.success = (upd.resolve_taken == upd.predict_taken) &&
                                      (upd.resolve_target == upd.predict_target);
                    end else begin
                        upd.result = cdb[i].payload.data.result;
                    end
                    next_entries[cdb[i].robn] = upd;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
            head  <= '0;
            tail  <= '0;
        end else begin
            count <= next_count;
            head  <= next_head;
            tail  <= next_tail;
        end
    end

    // entry storage
    always_ff @(posedge clock) begin
        rob_entries <= next_entries;
    end

endmodule

// File: hdl/rob_core_top.sv
`timescale 1ns/1ps

module rob_core_top (
    input  logic                                          clock,
    input  logic                                          reset,
    input  logic                                          disp_valid,
    input  rob_pkg::dispatch_group_t                      disp_group,
    input  rob_pkg::fu_rob_packet_t [rob_pkg::CDB_SZ-1:0] cdb,
    output logic                                          stall,
    output rob_pkg::robn_t [rob_pkg::WAYS-1:0]            disp_robn,
    output rob_pkg::retire_rec_t                          retire,
    output rob_pkg::redirect_t                            redirect
);

    import rob_pkg::*;

    logic                  almost_full;
    logic                  squash;
    robn_t [WAYS-1:0]      tail_entries;
    rob_is_packet_t        is_packet;
    rob_ct_packet_t        ct;

    dispatch_stage u_dispatch (
        .clock        (clock),
        .reset        (reset),
        .disp_valid   (disp_valid),
        .disp_group   (disp_group),
        .almost_full  (almost_full),
        .squash       (squash),
        .tail_entries (tail_entries),
        .stall        (stall),
        .disp_robn    (disp_robn),
        .is_packet    (is_packet)
    );

    rob u_rob (
        .clock        (clock),
        .reset        (reset),
        .is_packet    (is_packet),
        .cdb          (cdb),
        .almost_full  (almost_full),
        .tail_entries (tail_entries),
        .ct           (ct),
        .squash       (squash)
    );

    commit_unit u_commit (
        .clock    (clock),
        .reset    (reset),
        .ct       (ct),
        .squash   (squash),
        .retire   (retire),
        .redirect (redirect)
    );

endmodule

// File: hdl/rob_pkg.sv
package rob_pkg;

    localparam int WAYS      = 2;   // dispatch and retire width
    localparam int ROB_SZ    = 8;
    localparam int CDB_SZ    = 2;   // completion-bus lanes
    localparam int ROB_PTR_W = 3;
    localparam int ROB_CNT_W = 4;   // holds 0..ROB_SZ
    localparam int ARCH_REGS = 8;
    localparam int ARN_W     = 3;
    localparam int XLEN      = 32;

    typedef logic [ROB_PTR_W-1:0] robn_t;
    typedef logic [ARN_W-1:0]     arn_t;

    // one decoded instruction as handed to dispatch
    typedef struct packed {
        logic [XLEN-1:0] pc;
        arn_t            dest_arn;
        logic            wr_dest;        // writes dest_arn on retire
        logic            cond_branch;
        logic            uncond_branch;
        logic            predict_taken;
        logic [XLEN-1:0] predict_target;
    } dispatch_inst_t;

    typedef struct packed {
        logic [WAYS-1:0]            valid;
        dispatch_inst_t [WAYS-1:0]  insts;
    } dispatch_group_t;

    typedef struct packed {
        logic            executed;
        logic            success;        // cleared on mispredict
        logic            cond_branch;
        logic            uncond_branch;
        logic            predict_taken;
        logic            resolve_taken;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] predict_target;
        logic [XLEN-1:0] resolve_target;
        arn_t            dest_arn;
        logic            wr_dest;
        logic [XLEN-1:0] result;
    } rob_entry_t;

    typedef struct packed {
        logic [WAYS-1:0]        valid;
        rob_entry_t [WAYS-1:0]  entries;
    } rob_is_packet_t;

    // completion payload, meaning depends on the kind of the target entry
    typedef union packed {
        struct packed {
            logic            taken;
            logic [XLEN-1:0] target;
        } br;
        struct packed {
            logic            pad;
            logic [XLEN-1:0] result;
        } data;
    } fu_payload_u;

    typedef struct packed {
        logic        executed;
        robn_t       robn;
        fu_payload_u payload;
    } fu_rob_packet_t;

    typedef struct packed {
        logic [WAYS-1:0]        valid;
        rob_entry_t [WAYS-1:0]  entries;
    } rob_ct_packet_t;

    typedef struct packed {
        logic            valid;
        arn_t            dest;
        logic            wr;
        logic [XLEN-1:0] value;
    } retire_way_t;

    typedef struct packed {
        retire_way_t [WAYS-1:0] ways;
    } retire_rec_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;             // correct fetch address
    } redirect_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# builds and runs the ROB testbench with Verilator, run from the project root
rm -f sim.log
verilator --binary --timing -Wno-fatal -f verilog.f --top-module rob_tb -o rob_tb_sim \
    > build.log 2>&1 && ./obj_dir/rob_tb_sim > sim.log 2>&1 || echo "build or run error"
cat sim.log 2>/dev/null
grep -q "Simulation passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

// File: verilog.f
hdl/rob_pkg.sv
hdl/dispatch_stage.sv
hdl/rob.sv
hdl/commit_unit.sv
hdl/rob_core_top.sv
bench/rob_tb.sv
